// File: verilog/zb_consts.svh
`ifndef ZB_CONSTS_SVH
`define ZB_CONSTS_SVH

// bus widths
`define ZB_ADDR_W      32
`define ZB_DATA_W      32
`define ZB_CSR_IDX_W   3

// processor dram window, this bit pattern is xor-ed out of each address
`define ZB_DRAM_WINDOW 32'h8000_0000

// 120 MiB offset upper limit of the allocated region
`define ZB_MEM_LIMIT   32'h0780_0000

// profiler region field, address bits 29 down to 23
`define ZB_PROF_W      128
`define ZB_PROF_MSB    29
`define ZB_PROF_IDX_W  7

// host register map
`define ZB_CSR_RUN     3'd0
`define ZB_CSR_BASE    3'd1
`define ZB_CSR_PROF0   3'd2
`define ZB_CSR_PROF1   3'd3
`define ZB_CSR_PROF2   3'd4
`define ZB_CSR_PROF3   3'd5
`define ZB_CSR_COUNT   3'd6

`endif

// File: verilog/zb_pkg.sv
`include "zb_consts.svh"

package zb_pkg;

   typedef logic [`ZB_ADDR_W-1:0]     zb_addr_t;
   typedef logic [`ZB_DATA_W-1:0]     zb_word_t;
   typedef logic [`ZB_CSR_IDX_W-1:0]  zb_csr_idx_t;
   typedef logic [`ZB_PROF_IDX_W-1:0] zb_region_t;
   typedef logic [`ZB_PROF_W-1:0]     zb_bitmap_t;

   // processor side request, address still in the dram window
   typedef struct packed
   {
      logic     wr;
      zb_addr_t addr;
   } zb_mem_req_t;

   // request rebased into host physical memory
   typedef struct packed
   {
      logic     wr;
      zb_addr_t addr;
      // offset was at or above the upper limit
      logic     high;
   } zb_dram_req_t;

endpackage

// File: verilog/zb_dram_rebase.sv
`include "zb_consts.svh"

module zb_dram_rebase
   import zb_pkg::*;
(
   input  logic        aclk_i,
   input  logic        rst_n_i,

   // processor request, one strobe per request
   input  logic        req_v_i,
   input  zb_mem_req_t req_i,

   // to the profiler stage
   output logic        stg_v_o,
   output zb_mem_req_t stg_req_o,
   output logic        stg_high_o
);

   zb_addr_t    offset;
   logic        high;
   logic        stg_v_r;
   zb_mem_req_t stg_req_r;
   logic        stg_high_r;

   // flip the window bit to get the offset into the dram region
   // bits 29 to 23 pass through untouched, so the region index survives
   always_comb
   begin
      offset = req_i.addr ^ `ZB_DRAM_WINDOW;
      high   = (offset >= `ZB_MEM_LIMIT);
   end

   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
         stg_v_r <= 1'b0;
      else
         stg_v_r <= req_v_i;
   end

   // payload only loads on a valid request
   always_ff @(posedge aclk_i)
   begin
      if (req_v_i)
      begin
         stg_req_r.wr   <= req_i.wr;
         stg_req_r.addr <= offset;
         stg_high_r     <= high;
      end
   end

   assign stg_v_o    = stg_v_r;
   assign stg_req_o  = stg_req_r;
   assign stg_high_o = stg_high_r;

endmodule

// File: verilog/zb_mem_profiler.sv
`include "zb_consts.svh"

module zb_mem_profiler
   import zb_pkg::*;
(
   input  logic         aclk_i,
   input  logic         rst_n_i,

   // from the rebase stage
   input  logic         stg_v_i,
   input  zb_mem_req_t  stg_req_i,
   input  logic         stg_high_i,

   // control from the host registers
   input  logic         run_i,
   input  zb_addr_t     base_i,

   // rebased request towards host memory
   output logic         dram_v_o,
   output zb_dram_req_t dram_req_o,

   // profiler state back to the host registers
   output zb_bitmap_t   bitmap_o,
   output zb_word_t     count_o
);

   zb_addr_t     host_addr;
   zb_region_t   region;
   logic         dram_v_r;
   zb_dram_req_t dram_req_r;
   zb_bitmap_t   bitmap_r;
   zb_word_t     count_r;

   always_comb
   begin
      host_addr = stg_req_i.addr + base_i;
      region    = stg_req_i.addr[`ZB_PROF_MSB -: `ZB_PROF_IDX_W];
   end

   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
         dram_v_r <= 1'b0;
      else
         dram_v_r <= stg_v_i;
   end

   always_ff @(posedge aclk_i)
   begin
      if (stg_v_i)
      begin
         dram_req_r.wr   <= stg_req_i.wr;
         dram_req_r.addr <= host_addr;
         dram_req_r.high <= stg_high_i;
      end
   end

   // held clear while the processor is kept in reset
   // count wraps at 32 bits
   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i || !run_i)
      begin
         bitmap_r <= '0;
         count_r  <= '0;
      end
      else if (stg_v_i)
      begin
         bitmap_r[region] <= 1'b1;
         count_r          <= count_r + 1'b1;
      end
   end

   assign dram_v_o   = dram_v_r;
   assign dram_req_o = dram_req_r;
   assign bitmap_o   = bitmap_r;
   assign count_o    = count_r;

endmodule

// File: verilog/zb_csr_regs.sv
`include "zb_consts.svh"

module zb_csr_regs
   import zb_pkg::*;
(
   input  logic        aclk_i,
   input  logic        rst_n_i,

   // host access
   input  logic        csr_wr_v_i,
   input  logic        csr_rd_v_i,
   input  zb_csr_idx_t csr_idx_i,
   input  zb_word_t    csr_wdata_i,
   output zb_word_t    csr_rdata_o,
   output logic        csr_rdata_v_o,

   // profiler state, read only from the host
   input  zb_bitmap_t  bitmap_i,
   input  zb_word_t    count_i,

   // control levels
   output logic        run_o,
   output zb_addr_t    base_o
);

   logic     run_r;
   zb_addr_t base_r;
   zb_word_t rdata_r;
   logic     rdata_v_r;
   zb_word_t rdata_mux;

   // writable registers, writes to the other indices are dropped
   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         run_r  <= 1'b0;
         base_r <= '0;
      end
      else if (csr_wr_v_i)
      begin
         case (csr_idx_i)
            `ZB_CSR_RUN:  run_r  <= csr_wdata_i[0];
            `ZB_CSR_BASE: base_r <= csr_wdata_i;
            default:      ;
         endcase
      end
   end

   // read select, bitmap words go lowest word first
   always_comb
   begin
      case (csr_idx_i)
         `ZB_CSR_RUN:   rdata_mux = {{(`ZB_DATA_W-1){1'b0}}, run_r};
         `ZB_CSR_BASE:  rdata_mux = base_r;
         `ZB_CSR_PROF0: rdata_mux = bitmap_i[31:0];
         `ZB_CSR_PROF1: rdata_mux = bitmap_i[63:32];
         `ZB_CSR_PROF2: rdata_mux = bitmap_i[95:64];
         `ZB_CSR_PROF3: rdata_mux = bitmap_i[127:96];
         `ZB_CSR_COUNT: rdata_mux = count_i;
         default:       rdata_mux = '0;
      endcase
   end

   // read data comes back one cycle after the strobe
   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
         rdata_v_r <= 1'b0;
      else
         rdata_v_r <= csr_rd_v_i;
   end

   always_ff @(posedge aclk_i)
   begin
      if (csr_rd_v_i)
         rdata_r <= rdata_mux;
   end

   assign csr_rdata_o   = rdata_r;
   assign csr_rdata_v_o = rdata_v_r;
   // run also acts as the processor's reset release
   assign run_o         = run_r;
   assign base_o        = base_r;

endmodule

// File: verilog/zb_top.sv
module zb_top
   import zb_pkg::*;
(
   input  logic         aclk_i,
   input  logic         rst_n_i,

   // processor dram requests
   input  logic         req_v_i,
   input  zb_mem_req_t  req_i,
   output logic         dram_v_o,
   output zb_dram_req_t dram_req_o,

   // host register access
   input  logic         csr_wr_v_i,
   input  logic         csr_rd_v_i,
   input  zb_csr_idx_t  csr_idx_i,
   input  zb_word_t     csr_wdata_i,
   output zb_word_t     csr_rdata_o,
   output logic         csr_rdata_v_o,

   // processor reset control, low holds it in reset
   output logic         run_o
);

   logic        stg_v;
   zb_mem_req_t stg_req;
   logic        stg_high;
   zb_addr_t    base;
   zb_bitmap_t  bitmap;
   zb_word_t    count;

   zb_dram_rebase i_rebase
   (
      .aclk_i     (aclk_i),
      .rst_n_i    (rst_n_i),
      .req_v_i    (req_v_i),
      .req_i      (req_i),
      .stg_v_o    (stg_v),
      .stg_req_o  (stg_req),
      .stg_high_o (stg_high)
   );

   zb_mem_profiler i_profiler
   (
      .aclk_i     (aclk_i),
      .rst_n_i    (rst_n_i),
      .stg_v_i    (stg_v),
      .stg_req_i  (stg_req),
      .stg_high_i (stg_high),
      .run_i      (run_o),
      .base_i     (base),
      .dram_v_o   (dram_v_o),
      .dram_req_o (dram_req_o),
      .bitmap_o   (bitmap),
      .count_o    (count)
   );

   zb_csr_regs i_csr
   (
      .aclk_i        (aclk_i),
      .rst_n_i       (rst_n_i),
      .csr_wr_v_i    (csr_wr_v_i),
      .csr_rd_v_i    (csr_rd_v_i),
      .csr_idx_i     (csr_idx_i),
      .csr_wdata_i   (csr_wdata_i),
      .csr_rdata_o   (csr_rdata_o),
      .csr_rdata_v_o (csr_rdata_v_o),
      .bitmap_i      (bitmap),
      .count_i       (count),
      .run_o         (run_o),
      .base_o        (base)
   );

endmodule

// File: verification/zb_clk_gen.sv
module zb_clk_gen
(
   output logic clk_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // 10 ns period
   initial
   begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

endmodule

// File: verification/zb_chk.sv
module zb_chk
(
   input logic aclk_i,
   input logic rst_n_i,
   input logic req_v_i,
   input logic dram_v_i,
   input logic csr_rd_v_i,
   input logic rdata_v_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // every rebased request traces back to a strobe two cycles earlier
   dram_after_req: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      dram_v_i |-> $past(req_v_i, 2))
      else $error("dram_v_o high without a request strobe two cycles earlier");

   // read data valid follows the read strobe by one cycle, and only then
   rdata_after_rd: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      csr_rd_v_i |=> rdata_v_i)
      else $error("csr_rdata_v_o missing one cycle after csr_rd_v_i");

   rdata_needs_rd: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      rdata_v_i |-> $past(csr_rd_v_i))
      else $error("csr_rdata_v_o high without a read strobe");

   quiet_in_reset: assert property (@(posedge aclk_i)
      !rst_n_i |=> (!dram_v_i && !rdata_v_i))
      else $error("valid outputs not low in reset");

endmodule

bind zb_top zb_chk i_chk
(
   .aclk_i     (aclk_i),
   .rst_n_i    (rst_n_i),
   .req_v_i    (req_v_i),
   .dram_v_i   (dram_v_o),
   .csr_rd_v_i (csr_rd_v_i),
   .rdata_v_i  (csr_rdata_v_o)
);

// File: verification/zb_tb.sv
module zb_tb
   import zb_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [3:0] OP_WRITE = 4'h0;
   localparam logic [3:0] OP_READ  = 4'h1;
   localparam logic [3:0] OP_REQ   = 4'h2;

   // one line of the stimulus file
   typedef struct packed
   {
      logic [3:0] op;
      logic [3:0] arg;
      zb_word_t   val;
      zb_word_t   expv;
      logic       high;
   } cmd_t;

   // expected rebased request and the cycle its strobe was launched
   typedef struct packed
   {
      zb_dram_req_t req;
      logic [31:0]  cyc;
   } pend_t;

   logic         clk;
   logic         rst_n;
   logic         req_v;
   zb_mem_req_t  req;
   logic         dram_v;
   zb_dram_req_t dram_req;
   logic         csr_wr_v;
   logic         csr_rd_v;
   zb_csr_idx_t  csr_idx;
   zb_word_t     csr_wdata;
   zb_word_t     csr_rdata;
   logic         csr_rdata_v;
   logic         run;

   cmd_t         cmd_q[$];
   pend_t        pend_q[$];
   logic [31:0]  cyc;
   logic [31:0]  limit;

   zb_clk_gen i_clk
   (
      .clk_o (clk)
   );

   zb_top i_dut
   (
      .aclk_i        (clk),
      .rst_n_i       (rst_n),
      .req_v_i       (req_v),
      .req_i         (req),
      .dram_v_o      (dram_v),
      .dram_req_o    (dram_req),
      .csr_wr_v_i    (csr_wr_v),
      .csr_rd_v_i    (csr_rd_v),
      .csr_idx_i     (csr_idx),
      .csr_wdata_i   (csr_wdata),
      .csr_rdata_o   (csr_rdata),
      .csr_rdata_v_o (csr_rdata_v),
      .run_o         (run)
   );

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic wait_drained();
      while (pend_q.size() != 0)
         @(posedge clk);
   endtask

   task automatic write_reg(input zb_csr_idx_t idx, input zb_word_t data);
      wait_drained();
      @(posedge clk);
      csr_wr_v  <= 1'b1;
      csr_idx   <= idx;
      csr_wdata <= data;
      @(posedge clk);
      csr_wr_v  <= 1'b0;
   endtask

   task automatic read_reg(input zb_csr_idx_t idx, input zb_word_t expected);
      wait_drained();
      @(posedge clk);
      csr_rd_v <= 1'b1;
      csr_idx  <= idx;
      @(posedge clk);
      csr_rd_v <= 1'b0;
      @(posedge clk);
      while (!csr_rdata_v)
         @(posedge clk);
      assert (csr_rdata == expected)
      else
         abort_run($sformatf("ERR %0t: read of register %0d gave %h, expected %h",
                             $time, idx, csr_rdata, expected));
   endtask

   task automatic send_request(input cmd_t c);
      pend_t p;
      @(posedge clk);
      req_v      <= 1'b1;
      req        <= '{wr: c.arg[0], addr: c.val};
      p.req.wr   = c.arg[0];
      p.req.addr = c.expv;
      p.req.high = c.high;
      p.cyc      = cyc;
      pend_q.push_back(p);
   endtask

   task automatic end_requests();
      @(posedge clk);
      req_v <= 1'b0;
   endtask

   // response monitor and cycle limit
   always @(posedge clk)
   begin
      pend_t p;
      if (dram_v)
      begin
         assert (pend_q.size() > 0)
         else
            abort_run("dram_v_o rose with no request pending");
         p = pend_q.pop_front();
         assert (dram_req == p.req)
         else
            abort_run($sformatf("ERR %0t: dram request %h, expected %h",
                                $time, dram_req, p.req));
         // launched at edge k, captured at k+1, dram_v_o set at k+2, seen here at k+3
         assert (cyc == p.cyc + 3)
         else
            abort_run($sformatf("ERR %0t: dram request came at cycle %0d, expected %0d",
                                $time, cyc, p.cyc + 3));
      end
      assert (cyc < limit)
      else
         abort_run($sformatf("timeout: the run did not end within %0d cycles", limit));
      cyc <= cyc + 1;
   end

   initial
   begin
      int       fd;
      string    line;
      int       n;
      cmd_t     c;
      logic [3:0] op;
      logic [3:0] arg;
      zb_word_t val;
      zb_word_t expv;
      logic [3:0] high;

      rst_n     = 1'b0;
      req_v     = 1'b0;
      req       = '0;
      csr_wr_v  = 1'b0;
      csr_rd_v  = 1'b0;
      csr_idx   = '0;
      csr_wdata = '0;
      cyc       = '0;
      limit     = 32'hffff_ffff;

      fd = $fopen("verification/zb_input.txt", "r");
      assert (fd != 0)
      else
         abort_run("could not open verification/zb_input.txt");
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line.getc(0) != "#")
         begin
            n = $sscanf(line, "%h %h %h %h %h", op, arg, val, expv, high);
            assert (n == 5)
            else
               abort_run({"malformed line in the stimulus file: ", line});
            c = '{op: op, arg: arg, val: val, expv: expv, high: high[0]};
            cmd_q.push_back(c);
         end
      end
      $fclose(fd);
      limit = cmd_q.size() * 8 + 50;

      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      assert (run == 1'b0)
      else
         abort_run($sformatf("ERR %0t: run_o is high after reset", $time));

      for (int i = 0; i < cmd_q.size(); i++)
      begin
         case (cmd_q[i].op)
            OP_WRITE: write_reg(cmd_q[i].arg[2:0], cmd_q[i].val);
            OP_READ:  read_reg(cmd_q[i].arg[2:0], cmd_q[i].expv);
            OP_REQ:
            begin
               send_request(cmd_q[i]);
               // back-to-back requests keep the strobe high
               if (i == cmd_q.size() - 1 || cmd_q[i + 1].op != OP_REQ)
                  end_requests();
            end
            default:  abort_run("unknown command in the stimulus file");
         endcase
      end

      wait_drained();
      repeat (3) @(posedge clk);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: project.f
+incdir+verilog
verilog/zb_pkg.sv
verilog/zb_dram_rebase.sv
verilog/zb_mem_profiler.sv
verilog/zb_csr_regs.sv
verilog/zb_top.sv
verification/zb_clk_gen.sv
verification/zb_chk.sv
verification/zb_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the zb testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module zb_tb -f project.f -o zb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/zb_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished clean"
exit 0

// File: verification/zb_input.txt
# columns: cmd arg value expected high, all hex
# cmd 0 writes register arg, 1 reads register arg, 2 sends a request with write bit arg
1 0 00000000 00000000 0
1 1 00000000 00000000 0
1 2 00000000 00000000 0
1 3 00000000 00000000 0
1 4 00000000 00000000 0
1 5 00000000 00000000 0
1 6 00000000 00000000 0
1 7 00000000 00000000 0
0 1 23450000 00000000 0
1 1 00000000 23450000 0
0 0 00000001 00000000 0
1 0 00000000 00000001 0
2 1 80000000 23450000 0
2 0 80800000 23c50000 0
2 1 877ffffc 2ac4fffc 0
2 0 87800000 2ac50000 1
2 1 3f800000 e2c50000 1
1 2 00000000 0000c003 0
1 3 00000000 00000000 0
1 4 00000000 00000000 0
1 5 00000000 80000000 0
1 6 00000000 00000005 0
0 6 ffffffff 00000000 0
1 6 00000000 00000005 0
0 0 00000000 00000000 0
1 2 00000000 00000000 0
1 6 00000000 00000000 0
2 0 80000040 23450040 0
2 1 c1000000 64450000 1
1 2 00000000 00000000 0
1 5 00000000 00000000 0
1 6 00000000 00000000 0
